//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // values outside this list decode as nop
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_SLT   = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_LDI   = 6'd9,
        OP_JUMP  = 6'd10,
        OP_BRF   = 6'd11,
        OP_HALT  = 6'd12
    } opcode_e;

    // opcode in bits 5:0, immediate in the upper half
    typedef struct packed {
        logic [15:0] imm;
        logic        high_low;
        logic [2:0]  dest;
        logic [2:0]  src_b;
        logic [2:0]  src_a;
        logic [5:0]  opcode;
    } instr_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [31:0] result;
        logic        flag;
        logic        wr_en;
        logic        jump;
        logic [31:0] target;
    } alu_out_t;

    typedef struct packed {
        logic        en;
        logic [2:0]  idx;
        logic [31:0] data;
        logic        flag;
    } reg_write_t;

endpackage

`default_nettype wire

//--- verilog/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic [2:0]  sel_a,
    input  logic [2:0]  sel_b,
    output logic [31:0] rd_a_data,
    output logic        rd_a_flag,
    output logic [31:0] rd_b_data,
    output logic        rd_b_flag,
    input  reg_write_t  wr
);

    logic [31:0] regs [8];
    logic [7:0]  flags;

    // one write port, data and flag land together
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            regs <= '{default: '0};
            flags <= '0;
        end
        else if (wr.en)
        begin
            regs[wr.idx] <= wr.data;
            flags[wr.idx] <= wr.flag;
        end
    end

    // reads are combinational
    always_comb
    begin
        rd_a_data = regs[sel_a];
        rd_a_flag = flags[sel_a];
        rd_b_data = regs[sel_b];
        rd_b_flag = flags[sel_b];
    end

    a_idx_known: assert property (@(posedge clock) disable iff (rst)
        wr.en |-> !$isunknown(wr.idx));

endmodule

`default_nettype wire

//--- verilog/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu
    import cpu_pkg::*;
(
    input  instr_t      instr,
    input  logic [31:0] pc,
    input  logic [31:0] a,
    input  logic        a_flag,
    input  logic [31:0] b,
    output alu_out_t    out
);

    logic [32:0] sum;
    logic [32:0] diff;
    logic [31:0] imm_ext;

    // bit 32 holds carry for add and borrow for sub
    assign sum = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};
    assign imm_ext = {16'h0000, instr.imm};

    always_comb
    begin
        out = '0;
        case (instr.opcode)
            OP_ADD:
            begin
                out.result = sum[31:0];
                out.flag = sum[32];
                out.wr_en = 1'b1;
            end
            OP_SUB:
            begin
                out.result = diff[31:0];
                out.flag = diff[32];
                out.wr_en = 1'b1;
            end
            OP_AND:
            begin
                out.result = a & b;
                out.wr_en = 1'b1;
            end
            OP_OR:
            begin
                out.result = a | b;
                out.wr_en = 1'b1;
            end
            OP_XOR:
            begin
                out.result = a ^ b;
                out.wr_en = 1'b1;
            end
            OP_SLT:
            begin
                // unsigned compare, the borrow says a < b
                out.result = {31'b0, diff[32]};
                out.flag = diff[32];
                out.wr_en = 1'b1;
            end
            OP_LDI:
            begin
                out.result = instr.high_low ? {instr.imm, a[15:0]} : {a[31:16], instr.imm};
                out.wr_en = 1'b1;
            end
            OP_LOAD:
                out.wr_en = 1'b1;
            OP_JUMP:
            begin
                out.jump = 1'b1;
                out.target = imm_ext;
            end
            OP_BRF:
            begin
                // branch fully resolved here, fall through is pc+1
                out.jump = 1'b1;
                out.target = a_flag ? imm_ext : pc + 32'd1;
            end
            default:
                out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
)
(
    input  logic        clock,
    input  logic        rst,
    output wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp,
    output instr_t      instr,
    input  alu_out_t    alu,
    input  logic [31:0] rd_a_data,
    input  logic [31:0] rd_b_data,
    output reg_write_t  rd_write,
    output logic [31:0] pc,
    output logic        halted
);

    typedef enum logic [2:0] {
        PH_FETCH,
        PH_EXEC,
        PH_MEM,
        PH_ADV,
        PH_HALT
    } phase_e;

    phase_e      phase;
    logic        is_load;
    logic        is_store;
    logic [31:0] next_pc;

    assign is_load = (instr.opcode == OP_LOAD);
    assign is_store = (instr.opcode == OP_STORE);
    assign next_pc = alu.jump ? alu.target : pc + 32'd1;

    // alu ops write at the end of execute, loads on the data ack
    always_comb
    begin
        rd_write.en = (phase == PH_EXEC && alu.wr_en && !is_load) ||
                      (phase == PH_MEM && wb_rsp.ack && is_load);
        rd_write.idx = instr.dest;
        rd_write.data = is_load ? wb_rsp.dat : alu.result;
        rd_write.flag = is_load ? 1'b0 : alu.flag;
    end

    always_ff @(posedge clock)
    begin
        if (phase == PH_FETCH && wb_req.cyc && wb_rsp.ack)
            instr <= wb_rsp.dat;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            phase <= PH_FETCH;
            pc <= RESET_PC;
            wb_req <= '0;
            halted <= 1'b0;
        end
        else
        begin
            case (phase)
                PH_FETCH:
                begin
                    // first fetch after reset starts from idle
                    if (!wb_req.cyc)
                        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: pc, dat: '0};
                    else if (wb_rsp.ack)
                    begin
                        wb_req <= '0;
                        phase <= PH_EXEC;
                    end
                end
                PH_EXEC:
                begin
                    if (is_load || is_store)
                    begin
                        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: is_store,
                                    adr: is_store ? rd_b_data : rd_a_data,
                                    dat: rd_a_data};
                        phase <= PH_MEM;
                    end
                    else if (instr.opcode == OP_HALT)
                    begin
                        halted <= 1'b1;
                        phase <= PH_HALT;
                    end
                    else
                        phase <= PH_ADV;
                end
                PH_MEM:
                begin
                    if (wb_rsp.ack)
                    begin
                        wb_req <= '0;
                        phase <= PH_ADV;
                    end
                end
                PH_ADV:
                begin
                    // next fetch goes out together with the pc update
                    pc <= next_pc;
                    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: next_pc, dat: '0};
                    phase <= PH_FETCH;
                end
                default:
                    phase <= PH_HALT;
            endcase
        end
    end

    a_stb_cyc: assert property (@(posedge clock) disable iff (rst)
        wb_req.stb |-> wb_req.cyc && (phase == PH_FETCH || phase == PH_MEM));

    a_req_stable: assert property (@(posedge clock) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> $stable({wb_req.adr, wb_req.we, wb_req.dat}));

    a_write_phase: assert property (@(posedge clock) disable iff (rst)
        rd_write.en |-> (phase == PH_EXEC && !wb_req.cyc) ||
                        (phase == PH_MEM && wb_rsp.ack && wb_req.cyc && !wb_req.we));

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
)
(
    input  logic    clock,
    input  logic    rst,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output logic    halted
);

    instr_t      instr;
    alu_out_t    alu_out;
    reg_write_t  rd_write;
    logic [31:0] pc;
    logic [31:0] a_data;
    logic [31:0] b_data;
    logic        a_flag;

    cpu_control #(
        .RESET_PC(RESET_PC)
    ) u_control (
        .clock(clock),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .instr(instr),
        .alu(alu_out),
        .rd_a_data(a_data),
        .rd_b_data(b_data),
        .rd_write(rd_write),
        .pc(pc),
        .halted(halted)
    );

    // no opcode reads the b flag
    cpu_regfile u_regfile (
        .clock(clock),
        .rst(rst),
        .sel_a(instr.src_a),
        .sel_b(instr.src_b),
        .rd_a_data(a_data),
        .rd_a_flag(a_flag),
        .rd_b_data(b_data),
        .rd_b_flag(),
        .wr(rd_write)
    );

    cpu_alu u_alu (
        .instr(instr),
        .pc(pc),
        .a(a_data),
        .a_flag(a_flag),
        .b(b_data),
        .out(alu_out)
    );

endmodule

`default_nettype wire

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam logic [31:0] RESET_PC = 32'h0;
    localparam int RESET_CYCLES = 16;
    localparam int GOLDEN_WORDS = 128;
    localparam int MEM_WORDS = 64;
    localparam int HALT_TIMEOUT = 5000;
    localparam int QUIET_CYCLES = 50;

    logic    clock;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    halted;

    logic [31:0] golden [GOLDEN_WORDS];
    logic [31:0] mem [MEM_WORDS];
    int          error_count;
    int          check_count;
    int          store_count;
    int          expected_stores;
    int          read_count;
    logic [31:0] first_read_adr;
    logic [31:0] last_read_adr;
    logic        pending;
    int          wait_left;
    wb_req_t     held_req;

    cpu_top #(
        .RESET_PC(RESET_PC)
    ) DUT (
        .clock(clock),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .halted(halted)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    // stores are compared in order against the list from word 66 on
    task automatic record_store(input logic [31:0] adr, input logic [31:0] dat);
        int slot;
        slot = 66 + 2 * store_count;
        if (store_count >= expected_stores)
        begin
            $display("store number %0d to address %h was not expected", store_count, adr);
            error_count++;
        end
        else
        begin
            check_value("store address", adr, golden[slot]);
            check_value("store data", dat, golden[slot + 1]);
        end
        store_count++;
    endtask

    task automatic answer_request();
        logic [5:0] word;
        word = wb_req.adr[5:0];
        if (wb_req.adr[31:6] != '0)
        begin
            $display("bus access at address %h lies outside the memory", wb_req.adr);
            error_count++;
        end
        if (wb_req.we)
        begin
            mem[word] = wb_req.dat;
            record_store(wb_req.adr, wb_req.dat);
        end
        else
        begin
            if (read_count == 0)
                first_read_adr = wb_req.adr;
            last_read_adr = wb_req.adr;
            read_count++;
        end
        wb_rsp <= '{ack: 1'b1, dat: wb_req.we ? 32'h0 : mem[word]};
    endtask

    // memory slave serviced once per rising edge
    task automatic serve_bus();
        if (wb_rsp.ack)
        begin
            // the master drops cyc on this same edge
            wb_rsp <= '0;
            pending = 1'b0;
        end
        else if (wb_req.cyc && wb_req.stb)
        begin
            if (!pending)
            begin
                pending = 1'b1;
                held_req = wb_req;
                wait_left = $urandom % 4;
            end
            else
            begin
                check_value("held request address", wb_req.adr, held_req.adr);
                check_value("held request we", {31'b0, wb_req.we}, {31'b0, held_req.we});
                check_value("held request data", wb_req.dat, held_req.dat);
            end
            if (wait_left == 0)
                answer_request();
            else
                wait_left = wait_left - 1;
        end
    endtask

    task automatic check_reset_outputs();
        check_value("cyc in reset", {31'b0, wb_req.cyc}, 32'h0);
        check_value("stb in reset", {31'b0, wb_req.stb}, 32'h0);
        check_value("halted in reset", {31'b0, halted}, 32'h0);
    endtask

    initial
    begin
        int cycles;
        int stb_seen;

        rst <= 1'b1;
        wb_rsp <= '0;
        error_count = 0;
        check_count = 0;
        store_count = 0;
        read_count = 0;
        pending = 1'b0;
        wait_left = 0;
        held_req = '0;
        first_read_adr = '1;
        last_read_adr = '1;
        void'($urandom(32'h54a5));

        // unused words get a pattern built from the full word address
        for (int i = 0; i < GOLDEN_WORDS; i++)
            golden[i] = 32'ha5a5_0000 ^ i;
        $readmemh("testbench/cpu_golden.hex", golden);
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = golden[i];
        expected_stores = golden[64];

        // outputs are known from the second reset edge on
        for (int i = 1; i <= RESET_CYCLES; i++)
        begin
            @(posedge clock);
            if (i > 1)
                check_reset_outputs();
        end
        rst <= 1'b0;

        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT)
        begin
            @(posedge clock);
            if (cycles == 0)
                check_value("halted after reset", {31'b0, halted}, 32'h0);
            serve_bus();
            cycles++;
        end
        if (!halted)
        begin
            $display("timed out after %0d cycles waiting for the core to halt", cycles);
            error_count++;
        end

        // no bus activity once halted
        stb_seen = 0;
        for (int i = 0; i < QUIET_CYCLES; i++)
        begin
            @(posedge clock);
            serve_bus();
            if (wb_req.cyc || wb_req.stb)
                stb_seen++;
            check_value("halted held", {31'b0, halted}, 32'h1);
        end
        check_value("cyc or stb after halt", stb_seen, 32'h0);

        check_value("store count", store_count, golden[64]);
        check_value("first fetch address", first_read_adr, RESET_PC);
        check_value("halt fetch address", last_read_adr, golden[65]);

        $display("checks: %0d, errors: %0d, stores: %0d", check_count, error_count, store_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/cpu_pkg.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
testbench/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/cpu_golden.hex
// program image from word 00; from word 40: store count and halt word address,
// then one expected store per line as word address and data
@00
80009009 12341049 8000a009 00ff2089   // r1 = 80001234, r2 = 800000ff
00003441 003071c9 00000ec7            // add with carry, store
00004282 003171c9 00000f07            // sub with borrow, store
00005443 003271c9 00000f47            // and
00005444 003371c9 00000f47            // or
00005445 003471c9 00000f47            // xor
00005286 003571c9 00000f47            // slt
001900cb 003e71c9 00000e47            // brf taken, skips a store
003c000b 003671c9 00000f07            // brf on clear flag falls through
000061c8 003771c9 00000f87            // load back, store elsewhere
003c018b 0022000a 00000e47 0000000c   // load cleared the flag, jump over a store, halt
@40
00000008 00000022   // store count, halt address
00000030 00001333
00000031 ffffeecb
00000032 80000034
00000033 800012ff
00000034 000012cb
00000035 00000001
00000036 ffffeecb   // fall-through store
00000037 ffffeecb   // loaded value stored again
